//--- build.f
+incdir+testbench
hw/exec_pkg.sv
hw/alu_core.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/hilo_bank.sv
hw/exec_ctrl.sv
hw/exec_unit.sv
testbench/tb_exec_unit.sv

//--- run.sh
#!/bin/sh
# Compile the execute unit testbench with Verilator and run it
# Exit status is the simulation's own
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_exec_unit -o tb_exec_unit
./obj_dir/tb_exec_unit

//--- testbench/tb_ref_model.svh
// Reference model for the execute unit testbench
// ALU result and compare, 64-bit products, quotient and remainder
// Model HI/LO pair, updated when a multiply or divide issues
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] model_hi = '0;     // Zero out of reset
logic [31:0] model_lo = '0;

function automatic logic [31:0] model_alu(input exec_pkg::exec_op_t op,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [4:0] sh;
    sh = y[4:0];                // Low five bits only
    case (op)
        exec_pkg::op_add: return x + y;
        exec_pkg::op_sub: return x - y;
        exec_pkg::op_and: return x & y;
        exec_pkg::op_or:  return x | y;
        exec_pkg::op_xor: return x ^ y;
        exec_pkg::op_sll: return x << sh;
        exec_pkg::op_srl: return x >> sh;
        exec_pkg::op_sra: return $signed(x) >>> sh;
        default:          return 32'd0;
    endcase
endfunction

// Signed three-way compare, 01 less, 10 greater
function automatic logic [1:0] model_comp(input logic [31:0] x, input logic [31:0] y);
    if ($signed(x) < $signed(y)) begin
        return 2'b01;
    end else if ($signed(x) > $signed(y)) begin
        return 2'b10;
    end
    return 2'b00;
endfunction

function automatic logic [63:0] model_mul(input logic sgn, input logic [31:0] x,
                                          input logic [31:0] y);
    longint p;
    if (sgn) begin
        p = longint'($signed(x)) * longint'($signed(y));
    end else begin
        p = longint'({32'd0, x}) * longint'({32'd0, y});  // Wraps mod 2^64
    end
    return p;
endfunction

// {remainder, quotient}, done in 64 bits so INT_MIN / -1 cannot trap
function automatic logic [63:0] model_div(input logic sgn, input logic [31:0] x,
                                          input logic [31:0] y);
    longint n;
    longint d;
    longint q;
    longint r;
    if (y == 32'd0) begin
        return {x, 32'hffff_ffff};  // Divide by zero rule
    end
    n = sgn ? longint'($signed(x)) : longint'({32'd0, x});
    d = sgn ? longint'($signed(y)) : longint'({32'd0, y});
    q = n / d;
    r = n % d;                  // Sign follows the dividend
    return {r[31:0], q[31:0]};
endfunction

// Final HI/LO is always the last issued result
function automatic void model_issue(input exec_pkg::exec_op_t op, input logic [31:0] x,
                                    input logic [31:0] y);
    logic [63:0] v;
    case (op)
        exec_pkg::op_mult:  v = model_mul(1'b1, x, y);
        exec_pkg::op_multu: v = model_mul(1'b0, x, y);
        exec_pkg::op_div:   v = model_div(1'b1, x, y);
        exec_pkg::op_divu:  v = model_div(1'b0, x, y);
        default:            return;
    endcase
    model_hi = v[63:32];
    model_lo = v[31:0];
endfunction

`endif

//--- testbench/tb_exec_unit.sv
// Testbench for the execute unit
// Four-phase command driver, random ALU, multiply and divide stimulus
// Overlapped peer and back-to-back checks against the reference model

module tb_exec_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_wait = 200;  // Cycles allowed per handshake phase

    logic                 a;
    logic                 b;
    logic                 cmd_req;
    exec_pkg::exec_cmd_t  cmd;
    logic                 cmd_ack;
    exec_pkg::exec_resp_t resp;
    integer               seed = 32'h29d1_5201;

    `include "tb_ref_model.svh"

    exec_unit u_dut (
        .a       (a),
        .b       (b),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .resp    (resp)
    );

    always #50 a = ~a;  // 100 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // One full req/ack cycle, entered and left 10 ns after a rising edge
    task automatic run_cmd(input exec_pkg::exec_op_t op, input logic [31:0] x,
                           input logic [31:0] y, output exec_pkg::exec_resp_t r,
                           output int edges);
        int n;
        cmd.op  = op;
        cmd.a   = x;
        cmd.b   = y;
        cmd_req = 1'b1;
        n = 0;
        while (!cmd_ack && n < max_wait) begin
            @(posedge a);
            #10;
            n++;
        end
        if (!cmd_ack) begin
            abort_run($sformatf("Timeout: cmd_ack never rose for %s", op.name()));
        end
        r       = resp;         // Registered with the ack
        edges   = n;
        cmd_req = 1'b0;
        n = 0;
        while (cmd_ack && n < max_wait) begin
            @(posedge a);
            #10;
            n++;
        end
        if (cmd_ack) begin
            abort_run("Timeout: cmd_ack stayed high after cmd_req fell");
        end
    endtask

    task automatic alu_check(input exec_pkg::exec_op_t op, input logic [31:0] x,
                             input logic [31:0] y);
        exec_pkg::exec_resp_t r;
        int                   edges;
        run_cmd(op, x, y, r, edges);
        check_value($sformatf("%s result", op.name()), model_alu(op, x, y), r.result);
        check_value($sformatf("%s comp", op.name()), 32'(model_comp(x, y)), 32'(r.comp));
        check_value($sformatf("%s ack latency", op.name()), 32'd2, edges);
    endtask

    // Multiply or divide issue; fast means the target unit is known idle
    task automatic issue_op(input exec_pkg::exec_op_t op, input logic [31:0] x,
                            input logic [31:0] y, input bit fast);
        exec_pkg::exec_resp_t r;
        int                   edges;
        run_cmd(op, x, y, r, edges);
        model_issue(op, x, y);
        check_value($sformatf("%s issue resp", op.name()), 32'd0, r.result);
        check_value($sformatf("%s issue comp", op.name()), 32'd0, 32'(r.comp));
        if (fast) begin
            check_value($sformatf("%s issue latency", op.name()), 32'd2, edges);
        end else begin
            check_value($sformatf("%s held off", op.name()), 32'd1, {31'd0, edges > 2});
        end
    endtask

    task automatic read_hilo(input string tag);
        exec_pkg::exec_resp_t r;
        int                   edges;
        run_cmd(exec_pkg::op_mfhi, 32'd0, 32'd0, r, edges);
        check_value({tag, " hi"}, model_hi, r.result);
        run_cmd(exec_pkg::op_mflo, 32'd0, 32'd0, r, edges);
        check_value({tag, " lo"}, model_lo, r.result);
    endtask

    // Edge values about half the time
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'd0;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7fff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    initial begin
        logic [31:0]        r32;
        logic [31:0]        x;
        logic [31:0]        y;
        exec_pkg::exec_op_t op;
        a       = 1'b0;
        b       = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        repeat (4) @(posedge a);
        #10;
        b = 1'b0;

        read_hilo("after reset");   // Both zero

        for (int i = 0; i < 300; i++) begin
            r32 = $random(seed);
            op  = exec_pkg::exec_op_t'({1'b0, r32[2:0]});
            x   = pick_operand();
            y   = r32[8] ? {27'd0, r32[13:9]} : pick_operand();  // Small shift amounts
            alu_check(op, x, y);
        end

        for (int i = 0; i < 40; i++) begin
            r32 = $random(seed);
            op  = r32[0] ? exec_pkg::op_mult : exec_pkg::op_multu;
            issue_op(op, pick_operand(), pick_operand(), 1'b1);
            read_hilo(op.name());
        end

        // Directed divide corners
        issue_op(exec_pkg::op_div, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        read_hilo("div int_min by -1");
        issue_op(exec_pkg::op_div, 32'hffff_fff9, 32'd0, 1'b1);
        read_hilo("div by zero");
        issue_op(exec_pkg::op_divu, 32'h1234_5678, 32'd0, 1'b1);
        read_hilo("divu by zero");
        issue_op(exec_pkg::op_div, 32'hffff_fff9, 32'd2, 1'b1);  // -7 / 2
        read_hilo("div negative dividend");

        for (int i = 0; i < 40; i++) begin
            r32 = $random(seed);
            op  = r32[0] ? exec_pkg::op_div : exec_pkg::op_divu;
            x   = pick_operand();
            y   = r32[1] ? {{24{r32[7]}}, r32[7:0]} : pick_operand();  // Small +/- divisors
            issue_op(op, x, y, 1'b1);
            read_hilo(op.name());
        end

        // Peers in flight together, later issue wins
        issue_op(exec_pkg::op_mult, pick_operand(), pick_operand(), 1'b1);
        issue_op(exec_pkg::op_div, pick_operand(), 32'h0000_0013, 1'b1);
        read_hilo("mult then div");
        issue_op(exec_pkg::op_div, pick_operand(), 32'hffff_fffb, 1'b1);
        issue_op(exec_pkg::op_mult, pick_operand(), pick_operand(), 1'b1);
        read_hilo("div then mult");

        // Second multiply waits for the first to retire
        issue_op(exec_pkg::op_mult, 32'h1234_5678, 32'h9abc_def0, 1'b1);
        issue_op(exec_pkg::op_multu, 32'hfedc_ba98, 32'h7654_3210, 1'b0);
        read_hilo("back-to-back mult");

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- hw/exec_unit.sv
// Execute unit top level
// Controller, ALU, multiplier, divider and shared HI/LO bank

module exec_unit #(
    parameter int mul_bits_per_cycle = 2    // 1, 2 or 4
) (
    input  logic                 a,
    input  logic                 b,
    input  logic                 cmd_req,
    input  exec_pkg::exec_cmd_t  cmd,
    output logic                 cmd_ack,
    output exec_pkg::exec_resp_t resp
);

    exec_pkg::exec_op_t alu_op;
    logic [31:0]        alu_a;
    logic [31:0]        alu_b;
    logic [31:0]        alu_result;
    logic [1:0]         alu_comp;
    logic               mul_start;
    logic               div_start;
    logic               op_signed;
    logic [31:0]        op_a;
    logic [31:0]        op_b;
    logic               mul_busy;
    logic               div_busy;
    logic               mul_wr_req;
    logic               div_wr_req;
    logic               mul_grant;
    logic               div_grant;
    exec_pkg::hilo_wr_t mul_wr_data;
    exec_pkg::hilo_wr_t div_wr_data;
    logic [31:0]        hi;
    logic [31:0]        lo;

    exec_ctrl u_ctrl (
        .a          (a),
        .b          (b),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .resp       (resp),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_comp   (alu_comp),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .op_signed  (op_signed),
        .op_a       (op_a),
        .op_b       (op_b),
        .mul_busy   (mul_busy),
        .div_busy   (div_busy),
        .mul_wr_req (mul_wr_req),
        .div_wr_req (div_wr_req),
        .hi         (hi),
        .lo         (lo)
    );

    alu_core u_alu (
        .op     (alu_op),
        .alu_a  (alu_a),
        .alu_b  (alu_b),
        .result (alu_result),
        .comp   (alu_comp)
    );

    mul_unit #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) u_mul (
        .a         (a),
        .b         (b),
        .start     (mul_start),
        .op_signed (op_signed),
        .op_a      (op_a),
        .op_b      (op_b),
        .busy      (mul_busy),
        .wr_req    (mul_wr_req),
        .wr_data   (mul_wr_data),
        .grant     (mul_grant)
    );

    div_unit u_div (
        .a         (a),
        .b         (b),
        .start     (div_start),
        .op_signed (op_signed),
        .op_a      (op_a),
        .op_b      (op_b),
        .busy      (div_busy),
        .wr_req    (div_wr_req),
        .wr_data   (div_wr_data),
        .grant     (div_grant)
    );

    hilo_bank u_hilo (
        .a           (a),
        .b           (b),
        .mul_start   (mul_start),
        .div_start   (div_start),
        .mul_wr_req  (mul_wr_req),
        .div_wr_req  (div_wr_req),
        .mul_wr_data (mul_wr_data),
        .div_wr_data (div_wr_data),
        .mul_grant   (mul_grant),
        .div_grant   (div_grant),
        .hi          (hi),
        .lo          (lo)
    );

endmodule

//--- hw/exec_ctrl.sv
// Command port controller
// Four-phase req/ack handshake, dispatch to ALU, multiplier and divider
// Holds HI/LO reads until no write is pending

module exec_ctrl (
    input  logic                 a,
    input  logic                 b,
    input  logic                 cmd_req,
    input  exec_pkg::exec_cmd_t  cmd,
    output logic                 cmd_ack,
    output exec_pkg::exec_resp_t resp,
    output exec_pkg::exec_op_t   alu_op,
    output logic [31:0]          alu_a,
    output logic [31:0]          alu_b,
    input  logic [31:0]          alu_result,
    input  logic [1:0]           alu_comp,
    output logic                 mul_start,
    output logic                 div_start,
    output logic                 op_signed,
    output logic [31:0]          op_a,
    output logic [31:0]          op_b,
    input  logic                 mul_busy,
    input  logic                 div_busy,
    input  logic                 mul_wr_req,
    input  logic                 div_wr_req,
    input  logic [31:0]          hi,
    input  logic [31:0]          lo
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_ack,
        st_wait
    } ctrl_state_t;

    ctrl_state_t          state;
    logic                 is_mul;
    logic                 is_div;
    logic                 is_read;
    logic                 hilo_idle;
    logic                 go;       // Command can complete this cycle
    exec_pkg::exec_resp_t resp_d;

    // cmd is stable while cmd_req is high
    assign alu_op    = cmd.op;
    assign alu_a     = cmd.a;
    assign alu_b     = cmd.b;
    assign op_a      = cmd.a;
    assign op_b      = cmd.b;
    assign op_signed = (cmd.op == exec_pkg::op_mult) || (cmd.op == exec_pkg::op_div);

    assign is_mul  = (cmd.op == exec_pkg::op_mult) || (cmd.op == exec_pkg::op_multu);
    assign is_div  = (cmd.op == exec_pkg::op_div) || (cmd.op == exec_pkg::op_divu);
    assign is_read = (cmd.op == exec_pkg::op_mfhi) || (cmd.op == exec_pkg::op_mflo);

    // Read interlock
    assign hilo_idle = !(mul_busy || div_busy || mul_wr_req || div_wr_req);

    always_comb begin
        if (is_mul) begin
            go = !mul_busy;
        end else if (is_div) begin
            go = !div_busy;
        end else if (is_read) begin
            go = hilo_idle;
        end else begin
            go = 1'b1;      // Plain ALU op
        end
    end

    // One-cycle issue pulses
    assign mul_start = (state == st_exec) && is_mul && !mul_busy;
    assign div_start = (state == st_exec) && is_div && !div_busy;

    // Issue ops answer with zero
    always_comb begin
        resp_d = '0;
        if (cmd.op == exec_pkg::op_mfhi) begin
            resp_d.result = hi;
        end else if (cmd.op == exec_pkg::op_mflo) begin
            resp_d.result = lo;
        end else if (!is_mul && !is_div) begin
            resp_d.result = alu_result;
            resp_d.comp   = alu_comp;
        end
    end

    always_ff @(posedge a or posedge b) begin
        if (b) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (cmd_req) state <= st_exec;
                st_exec: if (go) state <= st_ack;
                st_ack:  state <= cmd_req ? st_wait : st_idle;
                st_wait: if (!cmd_req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Response captured on entry to ack
    always_ff @(posedge a) begin
        if (state == st_exec && go) begin
            resp <= resp_d;
        end
    end

    assign cmd_ack = (state == st_ack) || (state == st_wait);

endmodule

//--- hw/hilo_bank.sv
// HI/LO register pair shared by multiplier and divider
// Tracks issue order and grants writes oldest first, one per cycle

module hilo_bank (
    input  logic               a,
    input  logic               b,
    input  logic               mul_start,
    input  logic               div_start,
    input  logic               mul_wr_req,
    input  logic               div_wr_req,
    input  exec_pkg::hilo_wr_t mul_wr_data,
    input  exec_pkg::hilo_wr_t div_wr_data,
    output logic               mul_grant,
    output logic               div_grant,
    output logic [31:0]        hi,
    output logic [31:0]        lo
);

    logic mul_pend;     // Issued, not yet written
    logic div_pend;
    logic mul_first;    // Mul is older when both pending

    // A newer write waits for an older pending one
    assign mul_grant = mul_wr_req && (!div_pend || mul_first);
    assign div_grant = div_wr_req && (!mul_pend || !mul_first);

    always_ff @(posedge a or posedge b) begin
        if (b) begin
            mul_pend  <= 1'b0;
            div_pend  <= 1'b0;
            mul_first <= 1'b0;
            hi        <= '0;
            lo        <= '0;
        end else begin
            if (mul_start) begin
                mul_pend  <= 1'b1;
                mul_first <= !div_pend;
            end else if (mul_grant) begin
                mul_pend <= 1'b0;
            end
            if (div_start) begin
                div_pend  <= 1'b1;
                mul_first <= mul_pend;
            end else if (div_grant) begin
                div_pend <= 1'b0;
            end
            // Never both granted in one cycle
            if (mul_grant) begin
                hi <= mul_wr_data.hi;
                lo <= mul_wr_data.lo;
            end else if (div_grant) begin
                hi <= div_wr_data.hi;
                lo <= div_wr_data.lo;
            end
        end
    end

endmodule

//--- hw/div_unit.sv
// Iterative restoring divider, signed and unsigned
// 32 steps on magnitudes, then one sign fix-up cycle
// Divide by zero gives LO all ones and HI equal to the dividend

module div_unit (
    input  logic               a,
    input  logic               b,
    input  logic               start,
    input  logic               op_signed,
    input  logic [31:0]        op_a,
    input  logic [31:0]        op_b,
    output logic               busy,
    output logic               wr_req,
    output exec_pkg::hilo_wr_t wr_data,
    input  logic               grant
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix,
        st_hold
    } div_state_t;

    div_state_t  state;
    logic [5:0]  count;
    logic [31:0] rem;
    logic [31:0] quo;       // Dividend shifts out, quotient bits shift in
    logic [31:0] dvsr;
    logic        neg_q;
    logic        neg_r;
    logic        dz;        // Zero divisor seen at start
    logic [32:0] shifted;
    logic [32:0] diff;

    assign shifted = {rem, quo[31]};
    assign diff    = shifted - {1'b0, dvsr};  // Bit 32 set means restore

    always_ff @(posedge a or posedge b) begin
        if (b) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        count <= 6'd32;
                    end
                end
                st_run: begin
                    count <= count - 6'd1;
                    if (count == 6'd1) begin
                        state <= st_fix;
                    end
                end
                st_fix:  state <= st_hold;
                st_hold: begin
                    if (grant) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge a) begin
        if (start) begin
            rem   <= '0;
            quo   <= exec_pkg::magnitude(op_a, op_signed);
            dvsr  <= exec_pkg::magnitude(op_b, op_signed);
            neg_q <= op_signed && (op_a[31] ^ op_b[31]);
            neg_r <= op_signed && op_a[31];  // Remainder takes dividend sign
            dz    <= (op_b == 32'd0);
        end else if (state == st_run) begin
            rem <= diff[32] ? shifted[31:0] : diff[31:0];
            quo <= {quo[30:0], ~diff[32]};
        end else if (state == st_fix) begin
            wr_data.lo <= dz ? '1 : (neg_q ? (~quo + 32'd1) : quo);
            wr_data.hi <= neg_r ? (~rem + 32'd1) : rem;  // Equals a when dz
        end
    end

    assign busy   = (state != st_idle);
    assign wr_req = (state == st_hold);

endmodule

//--- hw/mul_unit.sv
// Iterative shift-add multiplier, signed and unsigned
// mul_bits_per_cycle partial products per cycle into a 64-bit accumulator
// Holds the product on wr_req until the HI/LO bank grants it

module mul_unit #(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic               a,
    input  logic               b,
    input  logic               start,
    input  logic               op_signed,
    input  logic [31:0]        op_a,
    input  logic [31:0]        op_b,
    output logic               busy,
    output logic               wr_req,
    output exec_pkg::hilo_wr_t wr_data,
    input  logic               grant
);

    localparam int steps = 32 / mul_bits_per_cycle;

    logic        running;
    logic [5:0]  count;
    logic [63:0] mcand;     // Shifts left each step
    logic [31:0] mplier;    // Shifts right each step
    logic [63:0] acc;
    logic [63:0] partial;
    logic        neg;

    // Sum of this cycle's partial products
    always_comb begin
        partial = acc;
        for (int j = 0; j < mul_bits_per_cycle; j++) begin
            if (mplier[j]) begin
                partial = partial + (mcand << j);
            end
        end
    end

    always_ff @(posedge a or posedge b) begin
        if (b) begin
            running <= 1'b0;
            wr_req  <= 1'b0;
            count   <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                count   <= 6'(steps);
            end else if (running) begin
                count <= count - 6'd1;
                if (count == 6'd1) begin  // Last step
                    running <= 1'b0;
                    wr_req  <= 1'b1;
                end
            end
            if (wr_req && grant) begin
                wr_req <= 1'b0;
            end
        end
    end

    // Datapath
    always_ff @(posedge a) begin
        if (start) begin
            mcand  <= {32'd0, exec_pkg::magnitude(op_a, op_signed)};
            mplier <= exec_pkg::magnitude(op_b, op_signed);
            acc    <= '0;
            neg    <= op_signed && (op_a[31] ^ op_b[31]);
        end else if (running) begin
            acc    <= partial;
            mcand  <= mcand << mul_bits_per_cycle;
            mplier <= mplier >> mul_bits_per_cycle;
        end
    end

    assign busy    = running || wr_req;           // Busy until granted
    assign wr_data = neg ? (~acc + 64'd1) : acc;  // Sign applied on the way out

endmodule

//--- hw/alu_core.sv
// Combinational ALU datapath
// Add, subtract, bitwise logic and shifts
// Signed three-way compare on every operation

module alu_core (
    input  exec_pkg::exec_op_t op,
    input  logic [31:0]        alu_a,
    input  logic [31:0]        alu_b,
    output logic [31:0]        result,
    output logic [1:0]         comp
);

    logic [4:0] shamt;

    assign shamt = alu_b[4:0];  // Only five bits count for shifts

    // Compare runs regardless of op
    always_comb begin
        if ($signed(alu_a) == $signed(alu_b)) begin
            comp = 2'b00;
        end else if ($signed(alu_a) < $signed(alu_b)) begin
            comp = 2'b01;
        end else begin
            comp = 2'b10;
        end
    end

    always_comb begin
        case (op)
            exec_pkg::op_add: result = alu_a + alu_b;
            exec_pkg::op_sub: result = alu_a - alu_b;
            exec_pkg::op_and: result = alu_a & alu_b;
            exec_pkg::op_or:  result = alu_a | alu_b;
            exec_pkg::op_xor: result = alu_a ^ alu_b;
            exec_pkg::op_sll: result = alu_a << shamt;
            exec_pkg::op_srl: result = alu_a >> shamt;
            exec_pkg::op_sra: result = $signed(alu_a) >>> shamt;  // Sign fill
            default:          result = '0;  // Mul, div and reads handled elsewhere
        endcase
    end

endmodule

//--- hw/exec_pkg.sv
// Shared types for the execute unit
// Operation codes, command and response words, HI/LO write word
// Operand magnitude helper for the multiplier and divider

package exec_pkg;

    // Codes 0..7 are the single-cycle ALU ops
    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,
        op_srl   = 4'd6,
        op_sra   = 4'd7,
        op_mult  = 4'd8,
        op_multu = 4'd9,
        op_div   = 4'd10,
        op_divu  = 4'd11,
        op_mfhi  = 4'd12,
        op_mflo  = 4'd13
    } exec_op_t;

    // 68-bit command word
    typedef struct packed {
        exec_op_t    op;
        logic [31:0] a;     // Shifted value for shifts
        logic [31:0] b;     // b[4:0] is the shift amount
    } exec_cmd_t;

    // 34-bit response word
    typedef struct packed {
        logic [31:0] result;
        logic [1:0]  comp;  // 00 eq, 01 a<b, 10 a>b (signed)
    } exec_resp_t;

    // 64-bit multiply or divide result
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } hilo_wr_t;

    // Two's complement magnitude when signed
    function automatic logic [31:0] magnitude(input logic [31:0] v, input logic sgn);
        return (sgn && v[31]) ? (~v + 32'd1) : v;
    endfunction

endpackage
